// ==== hdl/TexturePkg.sv ====
`default_nettype none

package TexturePkg;

    // One texel in RGB565
    // Red in the top five bits, blue in the bottom five
    typedef logic [15:0] TexelT;

    // Texture coordinate in S16.15 fixed point
    // Bit 31 is the sign
    // Bits 30..15 count whole texture repeats
    // Bits 14..0 give the position inside one repeat
    typedef logic signed [31:0] CoordT;

    // Log2 of a texture edge in texels
    // Valid range is 0 (1 texel) up to 8 (256 texels)
    typedef logic [3:0] SizeLog2T;

    // Level of detail, 0 is the full resolution base level
    // Each level halves both edges until an edge reaches one texel
    typedef logic [3:0] LodT;

    // Largest level the decoder can produce
    // Matches the eight-bit derivative window of the decoder
    localparam LodT LodMax = 4'd8;

endpackage

`default_nettype wire

// ==== hdl/LodCalculator.sv ====
`timescale 1ns/1ps
`default_nettype none

// Decode stage
// Picks the mip level from the texture coordinate step to the diagonal neighbour
module LodCalculator
    import TexturePkg::*;
#(
    parameter bit EnableLod = 1'b1
)
(
    input  wire             aclk,
    input  wire             rst,
    input  wire             lodEnable,
    input  wire SizeLog2T   widthLog2,
    input  wire SizeLog2T   heightLog2,
    input  wire CoordT      s,
    input  wire CoordT      t,
    input  wire CoordT      sXy,
    input  wire CoordT      tXy,
    output LodT             lod,
    output CoordT           sD,
    output CoordT           tD
);

    // Signed difference to the neighbour pixel
    CoordT      diffS;
    CoordT      diffT;
    // Magnitude inside one repeat
    logic [14:0] diffAbsS;
    logic [14:0] diffAbsT;
    // Derivative scaled to texels of the base level
    logic [7:0]  diffU;
    logic [7:0]  diffV;
    logic [7:0]  diffMax;
    LodT         lodNext;

    assign diffS = s - sXy;
    assign diffT = t - tXy;

    // Two's complement negate over the fraction when the difference is negative
    assign diffAbsS = diffS[31] ? 15'(~diffS[14:0] + 15'd1) : diffS[14:0];
    assign diffAbsT = diffT[31] ? 15'(~diffT[14:0] + 15'd1) : diffT[14:0];

    // Top eight fraction bits scaled down for smaller textures
    assign diffU = diffAbsS[14:7] >> (4'd8 - widthLog2);
    assign diffV = diffAbsT[14:7] >> (4'd8 - heightLog2);

    // OR keeps the leading one of the larger axis
    assign diffMax = diffU | diffV;

    // Leading one position plus one
    // Zero when no bit is set
    always_comb
    begin
        lodNext = '0;
        for (int i = 0; i < 8; i++)
        begin
            if (diffMax[i])
            begin
                lodNext = LodT'(i + 1);
            end
        end
    end

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            lod <= '0;
        end
        else if (EnableLod && lodEnable)
        begin
            lod <= lodNext;
        end
        else
        begin
            lod <= '0;
        end
    end

    // Coordinates travel alongside the level into the address stage
    always_ff @(posedge aclk)
    begin
        sD <= s;
        tD <= t;
    end

    // Level never passes the top of the chain of the texture it was decoded for
    assert property (@(posedge aclk) disable iff (rst)
        lod <= LodMax && (lod <= $past(widthLog2) || lod <= $past(heightLog2)));

endmodule

`default_nettype wire

// ==== hdl/MipAddressGen.sv ====
`timescale 1ns/1ps
`default_nettype none

// Execute stage
// Maps level and coordinates into a texel address of the packed mip chain
// Level 0 sits at address 0, each smaller level follows right after
module MipAddressGen
    import TexturePkg::*;
#(
    parameter int AddrWidth = 11
)
(
    input  wire                     aclk,
    input  wire SizeLog2T           widthLog2,
    input  wire SizeLog2T           heightLog2,
    input  wire LodT                lod,
    input  wire CoordT              sD,
    input  wire CoordT              tD,
    output logic [AddrWidth-1:0]    texAddr
);

    localparam int unsigned MemDepth = 2 ** AddrWidth;

    SizeLog2T    maxLog2;
    LodT         lodClamped;
    // Edges of the selected level
    SizeLog2T    levelWidthLog2;
    SizeLog2T    levelHeightLog2;
    logic [31:0] baseOffset;
    // Texel position inside the selected level
    logic [31:0] u;
    logic [31:0] v;
    logic [31:0] addrNext;

    // No level below a 1x1 texel
    assign maxLog2    = (widthLog2 > heightLog2) ? widthLog2 : heightLog2;
    assign lodClamped = (lod > maxLog2) ? maxLog2 : lod;

    // Each edge halves per level and floors at one texel
    assign levelWidthLog2  = (widthLog2 > lodClamped) ? widthLog2 - lodClamped : '0;
    assign levelHeightLog2 = (heightLog2 > lodClamped) ? heightLog2 - lodClamped : '0;

    // Base of a level is the summed area of all larger levels
    always_comb
    begin : OffsetSum
        SizeLog2T   edgeW;
        SizeLog2T   edgeH;
        logic [4:0] areaLog2;
        baseOffset = '0;
        for (int i = 0; i < int'(LodMax); i++)
        begin
            edgeW    = (widthLog2 > SizeLog2T'(i)) ? widthLog2 - SizeLog2T'(i) : '0;
            edgeH    = (heightLog2 > SizeLog2T'(i)) ? heightLog2 - SizeLog2T'(i) : '0;
            // Five bits since a 256x256 base has log2 area 16
            areaLog2 = 5'(edgeW) + 5'(edgeH);
            if (LodT'(i) < lodClamped)
            begin
                baseOffset = baseOffset + (32'd1 << areaLog2);
            end
        end
    end

    // Fraction only, which gives repeat wrapping for free
    assign u = {17'd0, sD[14:0]} >> (4'd15 - levelWidthLog2);
    assign v = {17'd0, tD[14:0]} >> (4'd15 - levelHeightLog2);

    // Row major inside the level
    assign addrNext = baseOffset + (v << levelWidthLog2) + u;

    always_ff @(posedge aclk)
    begin
        texAddr <= addrNext[AddrWidth-1:0];
    end

    // Texture and chain size must fit the memory, no silent wrap of the address
    assert property (@(posedge aclk) !$isunknown(addrNext) |-> addrNext < MemDepth);

endmodule

`default_nettype wire

// ==== hdl/TexelFetch.sv ====
`timescale 1ns/1ps
`default_nettype none

// Result stage
// On-chip texture memory, host writes on one port, lookups read on the other
module TexelFetch
    import TexturePkg::*;
#(
    parameter int AddrWidth = 11
)
(
    input  wire                     aclk,
    input  wire                     memWrite,
    input  wire [AddrWidth-1:0]     memAddr,
    input  wire TexelT              memData,
    input  wire [AddrWidth-1:0]     texAddr,
    output TexelT                   texel
);

    localparam int MemDepth = 2 ** AddrWidth;

    // Holds the whole packed mip chain
    TexelT texMem [MemDepth];

    // Host load port
    always_ff @(posedge aclk)
    begin
        if (memWrite)
        begin
            texMem[memAddr] <= memData;
        end
    end

    // Registered read, one texel per clock
    // A write shows up for reads from the next edge on
    always_ff @(posedge aclk)
    begin
        texel <= texMem[texAddr];
    end

    // Loads with an unknown address would corrupt arbitrary words
    assert property (@(posedge aclk) memWrite |-> !$isunknown(memAddr));

endmodule

`default_nettype wire

// ==== hdl/TextureLookup.sv ====
`timescale 1ns/1ps
`default_nettype none

// Mip-mapped texture lookup in three register stages
// Decode, execute, result
module TextureLookup
    import TexturePkg::*;
#(
    parameter bit EnableLod = 1'b1,
    parameter int AddrWidth = 11
)
(
    input  wire                     aclk,
    input  wire                     rst,
    // Lookup
    input  wire                     inValid,
    input  wire CoordT              s,
    input  wire CoordT              t,
    input  wire CoordT              sXy,
    input  wire CoordT              tXy,
    // Configuration held steady while lookups run
    input  wire                     lodEnable,
    input  wire SizeLog2T           widthLog2,
    input  wire SizeLog2T           heightLog2,
    // Texture load
    input  wire                     memWrite,
    input  wire [AddrWidth-1:0]     memAddr,
    input  wire TexelT              memData,
    // Result
    output logic                    outValid,
    output TexelT                   texel
);

    LodT                    lod;
    CoordT                  sD;
    CoordT                  tD;
    logic [AddrWidth-1:0]   texAddr;
    // One bit per stage
    // Nothing stalls so it just shifts
    logic [2:0]             validPipe;

    LodCalculator #(
        .EnableLod  (EnableLod)
    ) LodCalculator_inst (
        .aclk       (aclk),
        .rst        (rst),
        .lodEnable  (lodEnable),
        .widthLog2  (widthLog2),
        .heightLog2 (heightLog2),
        .s          (s),
        .t          (t),
        .sXy        (sXy),
        .tXy        (tXy),
        .lod        (lod),
        .sD         (sD),
        .tD         (tD)
    );

    MipAddressGen #(
        .AddrWidth  (AddrWidth)
    ) MipAddressGen_inst (
        .aclk       (aclk),
        .widthLog2  (widthLog2),
        .heightLog2 (heightLog2),
        .lod        (lod),
        .sD         (sD),
        .tD         (tD),
        .texAddr    (texAddr)
    );

    TexelFetch #(
        .AddrWidth  (AddrWidth)
    ) TexelFetch_inst (
        .aclk       (aclk),
        .memWrite   (memWrite),
        .memAddr    (memAddr),
        .memData    (memData),
        .texAddr    (texAddr),
        .texel      (texel)
    );

    // Valid strobe delay matches the three data stages
    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            validPipe <= '0;
        end
        else
        begin
            validPipe <= {validPipe[1:0], inValid};
        end
    end

    assign outValid = validPipe[2];

endmodule

`default_nettype wire

// ==== testbench/TextureLookupTb.sv ====
`timescale 1ns/1ps
`default_nettype none

// Directed tests for the mip-mapped texture lookup
// Memory word n holds n, so every texel names the address that was read
module TextureLookupTb
    import TexturePkg::*;
();

    localparam int ClkPeriod = 40;
    localparam int DriveDelay = 2;
    localparam int ResetCycles = 8;
    localparam bit EnableLod = 1'b1;
    localparam int AddrWidth = 11;
    localparam int LoadCycles = 2 ** AddrWidth;
    localparam int RandomLookups = 40;
    // Cycle budget per test, used by the watchdog
    localparam int ResetValidCycles = 20;
    localparam int LodOffCycles = 16;
    localparam int LevelStepCycles = 24;
    localparam int NonSquareCycles = 32;
    localparam int WrapCycles = RandomLookups + 16;
    localparam int MarginCycles = 200;
    localparam int WatchdogCycles = ResetCycles + LoadCycles + ResetValidCycles + LodOffCycles
        + LevelStepCycles + NonSquareCycles + WrapCycles + MarginCycles;

    logic                   aclk;
    logic                   rst;
    logic                   inValid;
    CoordT                  s;
    CoordT                  t;
    CoordT                  sXy;
    CoordT                  tXy;
    logic                   lodEnable;
    SizeLog2T               widthLog2;
    SizeLog2T               heightLog2;
    logic                   memWrite;
    logic [AddrWidth-1:0]   memAddr;
    TexelT                  memData;
    logic                   outValid;
    TexelT                  texel;

    // Lookups in flight, oldest first
    TexelT                  expQ[$];
    int                     dueQ[$];
    string                  nameQ[$];
    int                     cycleCount = 0;
    logic [15:0]            lfsrState;

    TextureLookup #(
        .EnableLod  (EnableLod),
        .AddrWidth  (AddrWidth)
    ) TextureLookup_inst (
        .aclk       (aclk),
        .rst        (rst),
        .inValid    (inValid),
        .s          (s),
        .t          (t),
        .sXy        (sXy),
        .tXy        (tXy),
        .lodEnable  (lodEnable),
        .widthLog2  (widthLog2),
        .heightLog2 (heightLog2),
        .memWrite   (memWrite),
        .memAddr    (memAddr),
        .memData    (memData),
        .outValid   (outValid),
        .texel      (texel)
    );

    always #(ClkPeriod / 2) aclk = ~aclk;

    // Edge counter, lets the checker see the exact arrival cycle
    always @(posedge aclk)
    begin
        cycleCount <= cycleCount + 1;
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic compareTexel(input string testName, input TexelT expected, input TexelT actual);
        if (actual !== expected)
        begin
            failRun($sformatf("FAIL %s expected 0x%04h actual 0x%04h", testName, expected, actual));
        end
    endtask

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            value = {value[30:0], lfsrState[15]};
            feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], feedback};
        end
        return value;
    endfunction

    // Edge log2 at a level, never below one texel
    function automatic int levelEdge(input int baseLog2, input int level);
        return (baseLog2 > level) ? baseLog2 - level : 0;
    endfunction

    // Reference model of decode and address rules
    function automatic int expectedAddress(input CoordT sIn, input CoordT tIn, input CoordT sN,
        input CoordT tN, input logic lodOn, input SizeLog2T wl2, input SizeLog2T hl2);
        int dS;
        int dT;
        int magS;
        int magT;
        int bits;
        int level;
        int topLevel;
        int base;
        int lw;
        int lh;
        int u;
        int v;
        dS = sIn - sN;
        dT = tIn - tN;
        // Magnitude of the step inside one repeat
        magS = (dS < 0) ? ((-dS) & 'h7fff) : (dS & 'h7fff);
        magT = (dT < 0) ? ((-dT) & 'h7fff) : (dT & 'h7fff);
        bits = ((magS >> 7) >> (8 - int'(wl2))) | ((magT >> 7) >> (8 - int'(hl2)));
        level = 0;
        while (bits != 0)
        begin
            level++;
            bits = bits >> 1;
        end
        if (!(lodOn && EnableLod))
        begin
            level = 0;
        end
        topLevel = (wl2 > hl2) ? int'(wl2) : int'(hl2);
        if (level > topLevel)
        begin
            level = topLevel;
        end
        // Larger levels come first in the chain
        base = 0;
        for (int i = 0; i < level; i++)
        begin
            base += (1 << levelEdge(wl2, i)) * (1 << levelEdge(hl2, i));
        end
        lw = levelEdge(wl2, level);
        lh = levelEdge(hl2, level);
        u = (sIn & 'h7fff) >> (15 - lw);
        v = (tIn & 'h7fff) >> (15 - lh);
        return base + v * (1 << lw) + u;
    endfunction

    task automatic stepCycle();
        @(posedge aclk);
        #(DriveDelay);
    endtask

    task automatic idleCycles(input int count);
        inValid = 1'b0;
        repeat (count) stepCycle();
    endtask

    // Wait until every lookup in flight came back, the watchdog guards a hang
    task automatic drainPipeline();
        inValid = 1'b0;
        while (dueQ.size() != 0)
        begin
            stepCycle();
        end
    endtask

    // Only called with an empty pipeline
    task automatic setTexture(input SizeLog2T w, input SizeLog2T h, input logic en);
        widthLog2 = w;
        heightLog2 = h;
        lodEnable = en;
        stepCycle();
    endtask

    task automatic loadTexture();
        for (int a = 0; a < LoadCycles; a++)
        begin
            memWrite = 1'b1;
            memAddr = a[AddrWidth-1:0];
            memData = TexelT'(a);
            stepCycle();
        end
        memWrite = 1'b0;
    endtask

    // Drive one lookup for one cycle and queue its expected texel
    task automatic issueLookup(input string testName, input CoordT sIn, input CoordT tIn,
        input CoordT sN, input CoordT tN);
        TexelT expected;
        expected = TexelT'(expectedAddress(sIn, tIn, sN, tN, lodEnable, widthLog2, heightLog2));
        inValid = 1'b1;
        s = sIn;
        t = tIn;
        sXy = sN;
        tXy = tN;
        expQ.push_back(expected);
        // Sampled at the next edge, three edges later outValid is high
        dueQ.push_back(cycleCount + 3);
        nameQ.push_back(testName);
        stepCycle();
    endtask

    task automatic testResetValid();
        idleCycles(6);
        setTexture(4'd5, 4'd5, 1'b1);
        issueLookup("resetValid", 32'sh0000_2468, 32'sh0000_1357, 32'sh0000_2468,
            32'sh0000_1357);
        idleCycles(5);
        issueLookup("resetValidSecond", 32'sh0000_7000, 32'sh0000_0400, 32'sh0000_7000,
            32'sh0000_0400);
        drainPipeline();
    endtask

    task automatic testLodOff();
        setTexture(4'd5, 4'd5, 1'b0);
        // Large steps on both axes, still the base level
        issueLookup("lodOff", 32'sh0000_4100, 32'sh0000_2300, 32'sh0000_8100, 32'sh0000_5300);
        issueLookup("lodOffWide", 32'sh0000_1230, 32'sh0000_6540, 32'sh0000_7fff, 32'sh0000_0000);
        drainPipeline();
    endtask

    task automatic testLevelSteps();
        CoordT sBase;
        CoordT tBase;
        sBase = 32'sh0000_3a80;
        tBase = 32'sh0000_5c40;
        setTexture(4'd5, 4'd5, 1'b1);
        issueLookup("flatLevel", sBase, tBase, sBase, tBase);
        // 1 << 10 is one base texel on a 32 wide texture
        for (int k = 0; k < 5; k++)
        begin
            issueLookup($sformatf("levelStep%0d", k), sBase, tBase, sBase + (32'sd1 << (10 + k)),
                tBase);
        end
        // Widest step, level sits at the 1x1 top of the chain
        issueLookup("levelTop", sBase, tBase, sBase + 32'sh0000_7fff, tBase + 32'sh0000_7fff);
        drainPipeline();
    endtask

    task automatic testNonSquare();
        CoordT sBase;
        CoordT tBase;
        sBase = 32'sh0000_6ac0;
        tBase = 32'sh0000_5a40;
        setTexture(4'd5, 4'd5, 1'b1);
        issueLookup("negDiffPlus", sBase, tBase, sBase + 32'sh0000_0800, tBase);
        issueLookup("negDiffMinus", sBase, tBase, sBase - 32'sh0000_0800, tBase);
        drainPipeline();
        // 32 by 8, the short edge reaches one texel first
        setTexture(4'd5, 4'd3, 1'b1);
        for (int k = 0; k < 5; k++)
        begin
            issueLookup($sformatf("wideStepS%0d", k), sBase, tBase, sBase - (32'sd1 << (10 + k)),
                tBase);
            issueLookup($sformatf("wideStepT%0d", k), sBase, tBase, sBase,
                tBase + (32'sd1 << (10 + k)));
        end
        drainPipeline();
    endtask

    task automatic testWrapAndRandom();
        CoordT       sR;
        CoordT       tR;
        logic [31:0] delta;
        setTexture(4'd5, 4'd5, 1'b1);
        // Whole repeats and negative coordinates keep only the fraction
        issueLookup("wrapPositive", 32'sh0003_1234, 32'sh0007_0abc, 32'sh0003_1234,
            32'sh0007_0abc);
        issueLookup("wrapNegative", -32'sh0001_2000, -32'sh0000_0100, -32'sh0001_2000,
            -32'sh0000_0100);
        // Back to back, results must return in issue order
        for (int n = 0; n < RandomLookups; n++)
        begin
            sR = CoordT'(randomBits(32));
            tR = CoordT'(randomBits(32));
            delta = randomBits(32);
            issueLookup($sformatf("random%0d", n), sR, tR,
                sR + CoordT'($signed(delta[15:0])), tR + CoordT'($signed(delta[31:16])));
        end
        drainPipeline();
    endtask

    // Sample on the falling edge where outputs are settled
    always @(negedge aclk)
    begin
        if (!rst)
        begin
            if (outValid === 1'b1)
            begin
                if (dueQ.size() == 0)
                begin
                    failRun("outValid went high with no lookup in flight");
                end
                else if (dueQ[0] != cycleCount)
                begin
                    failRun($sformatf("outValid for %s came at cycle %0d, due at cycle %0d",
                        nameQ[0], cycleCount, dueQ[0]));
                end
                else
                begin
                    compareTexel(nameQ[0], expQ[0], texel);
                    void'(expQ.pop_front());
                    void'(dueQ.pop_front());
                    void'(nameQ.pop_front());
                end
            end
            else if (dueQ.size() != 0 && dueQ[0] <= cycleCount)
            begin
                failRun($sformatf("outValid for %s missing at cycle %0d", nameQ[0], dueQ[0]));
            end
        end
    end

    initial
    begin
        #(ClkPeriod * WatchdogCycles);
        failRun("watchdog timeout, the run took longer than the tests allow");
    end

    initial
    begin
        aclk = 1'b0;
        rst = 1'b1;
        inValid = 1'b0;
        s = '0;
        t = '0;
        sXy = '0;
        tXy = '0;
        lodEnable = 1'b0;
        widthLog2 = '0;
        heightLog2 = '0;
        memWrite = 1'b0;
        memAddr = '0;
        memData = '0;
        lfsrState = 16'd54;
        repeat (ResetCycles) stepCycle();
        rst = 1'b0;
        loadTexture();
        testResetValid();
        testLodOff();
        testLevelSteps();
        testNonSquare();
        testWrapAndRandom();
        if (dueQ.size() == 0)
        begin
            $display("all tests passed");
            $finish;
        end
        else
        begin
            failRun("lookups still in flight at the end of the run");
        end
    end

endmodule

`default_nettype wire

// ==== TextureLookup.f ====
hdl/TexturePkg.sv
hdl/LodCalculator.sv
hdl/MipAddressGen.sv
hdl/TexelFetch.sv
hdl/TextureLookup.sv
testbench/TextureLookupTb.sv

// ==== Makefile ====
# Verilator build for the texture lookup testbench
# Override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= TextureLookupTb
FILELIST  ?= TextureLookup.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The log decides pass or fail
run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "simulation result: pass" || \
		{ echo "simulation result: fail"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
